// ==== dma_config.svh ====
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Byte address width of the AXI write port.
`define DMA_ADDR_W 32

// One cache line per beat.
`define DMA_DATA_W 64

// Send FIFO holds 2**5 = 32 lines.
`define DMA_FIFO_LOG2 5

// Almost-full when this many entries or fewer are free.
`define DMA_FIFO_AF_MARGIN 4

// Beats in a full burst, 128 bytes at 64-bit data.
`define DMA_BURST_LEN 16

`endif

// ==== dma_pkg.sv ====
`include "dma_config.svh"

package dma_pkg;

    // Byte address on the AXI side.
    typedef logic [`DMA_ADDR_W-1:0] addr_t;

    // One line of payload, moved as a single W beat.
    typedef logic [`DMA_DATA_W-1:0] data_t;

    typedef logic [`DMA_DATA_W/8-1:0] strb_t;  // One enable per byte.

    // Transfer length in lines.
    typedef logic [31:0] len_t;

    typedef logic [7:0] awlen_t;  // AXI beat count minus one.

    // Transfer FSM of the controller.
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_WRITE,
        ST_DONE
    } wr_state_t;

endpackage

// ==== dma_if.sv ====
`timescale 1ns/1ps

interface burst_cmd_if;
    import dma_pkg::*;

    // Command from the controller, held until cmd_done.
    logic  cmd_start;   // One-cycle pulse.
    addr_t cmd_addr;
    len_t  cmd_length;  // In lines.

    // Completion and response reporting from the burst master.
    logic  cmd_done;    // One-cycle pulse after the last B response.
    logic  b_seen;      // Pulses once per accepted B response.
    logic  b_err;       // Qualifies b_seen when bresp is not OKAY.

    modport ctrl
    (
        output cmd_start,
        output cmd_addr,
        output cmd_length,
        input  cmd_done,
        input  b_seen,
        input  b_err
    );

    modport master
    (
        input  cmd_start,
        input  cmd_addr,
        input  cmd_length,
        output cmd_done,
        output b_seen,
        output b_err
    );

endinterface

// ==== dma_send_fifo.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_send_fifo
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  dma_pkg::data_t wr_data,
    output logic           tvalid,
    input  logic           tready,
    output dma_pkg::data_t tdata,
    output logic           almost_full
);
    import dma_pkg::*;

    localparam int DEPTH = 1 << `DMA_FIFO_LOG2;

    data_t                    mem [DEPTH];
    logic [`DMA_FIFO_LOG2-1:0] wr_ptr;
    logic [`DMA_FIFO_LOG2-1:0] rd_ptr;
    logic [`DMA_FIFO_LOG2:0]   count;  // One bit wider than the pointers.
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full = (count == DEPTH[`DMA_FIFO_LOG2:0]);
    assign push = wr_en && !full;  // A push into a full FIFO is dropped.
    assign pop  = tvalid && tready;

    // Fall-through output, the head entry is visible while not empty.
    assign tvalid = (count != '0);
    assign tdata  = mem[rd_ptr];

    assign almost_full = (count >= (DEPTH - `DMA_FIFO_AF_MARGIN));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH.
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // Producer must honor almost_full and never push into a full FIFO.
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && full));

endmodule

// ==== dma_axi_write_master.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_axi_write_master
(
    input  logic            clk,
    input  logic            rst_n,
    burst_cmd_if.master     cmd,
    input  logic            tvalid,
    output logic            tready,
    input  dma_pkg::data_t  tdata,
    output logic            awvalid,
    input  logic            awready,
    output dma_pkg::addr_t  awaddr,
    output dma_pkg::awlen_t awlen,
    output logic            wvalid,
    input  logic            wready,
    output dma_pkg::data_t  wdata,
    output dma_pkg::strb_t  wstrb,
    output logic            wlast,
    input  logic            bvalid,
    output logic            bready,
    input  logic [1:0]      bresp
);
    import dma_pkg::*;

    localparam len_t  BURST_LINES = len_t'(`DMA_BURST_LEN);
    localparam addr_t BURST_BYTES = addr_t'(`DMA_BURST_LEN * `DMA_DATA_W / 8);

    logic   active;
    addr_t  next_addr;    // Start of the following burst.
    len_t   lines_left;   // Lines not yet covered by an AW.
    awlen_t beats_left;   // Beats after the current one.
    logic   w_busy;       // Data phase of the accepted burst.
    len_t   outstanding;  // Bursts still waiting for B.
    logic   done_q;

    logic   aw_fire;
    logic   w_fire;
    logic   b_fire;
    logic   issue;
    logic   final_b;
    addr_t  src_addr;
    len_t   src_lines;
    len_t   burst_lines;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // First burst comes straight from the command, the rest follow each wlast.
    assign issue     = cmd.cmd_start ? (cmd.cmd_length != '0)
                                     : (w_fire && wlast && lines_left != '0);
    assign src_addr  = cmd.cmd_start ? cmd.cmd_addr : next_addr;
    assign src_lines = cmd.cmd_start ? cmd.cmd_length : lines_left;
    assign burst_lines = (src_lines > BURST_LINES) ? BURST_LINES : src_lines;

    // Last response: nothing left to address, no data phase, one burst pending.
    assign final_b = b_fire && (outstanding == len_t'(1)) && (lines_left == '0)
                     && !awvalid && !w_busy;

    // W beats come straight from the FIFO head.
    assign wvalid = w_busy && tvalid;
    assign tready = w_busy && wready;
    assign wdata  = tdata;
    assign wstrb  = '1;
    assign wlast  = w_busy && (beats_left == '0);

    assign bready = active;

    assign cmd.cmd_done = done_q;
    assign cmd.b_seen   = b_fire;
    assign cmd.b_err    = b_fire && (bresp != 2'b00);  // Anything but OKAY.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active      <= 1'b0;
            done_q      <= 1'b0;
            awvalid     <= 1'b0;
            lines_left  <= '0;
            beats_left  <= '0;
            w_busy      <= 1'b0;
            outstanding <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (cmd.cmd_start)
                active <= 1'b1;
            else if (final_b)
            begin
                active <= 1'b0;
                done_q <= 1'b1;
            end

            if (issue)
            begin
                awvalid    <= 1'b1;
                lines_left <= src_lines - burst_lines;
            end
            else if (aw_fire)
                awvalid <= 1'b0;

            // Data phase opens once the address is taken.
            if (aw_fire)
            begin
                w_busy     <= 1'b1;
                beats_left <= awlen;
            end
            else if (w_fire)
            begin
                if (wlast)
                    w_busy <= 1'b0;
                else
                    beats_left <= beats_left - 1'b1;
            end

            if (aw_fire && !b_fire)
                outstanding <= outstanding + 1'b1;
            else if (b_fire && !aw_fire)
                outstanding <= outstanding - 1'b1;
        end
    end

    // AW payload, loaded with each new burst.
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            awaddr    <= src_addr;
            awlen     <= awlen_t'(burst_lines - 1'b1);
            next_addr <= src_addr + BURST_BYTES;
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

    a_b_expected: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> outstanding != '0);

endmodule

// ==== dma_write_ctrl.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_write_ctrl
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  dma_pkg::addr_t start_addr,
    input  dma_pkg::len_t  length,
    burst_cmd_if.ctrl      cmd,
    output logic           status_idle,
    output logic           status_active,
    output logic           done,
    output logic           ack,
    output logic           resp_error
);
    import dma_pkg::*;

    localparam int BURST_BYTES = `DMA_BURST_LEN * `DMA_DATA_W / 8;

    wr_state_t state;
    logic      accept;

    assign accept = (state == ST_IDLE) && start;

    assign status_idle   = (state == ST_IDLE);
    assign status_active = (state == ST_WRITE);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= ST_IDLE;
            cmd.cmd_start <= 1'b0;
            done          <= 1'b0;
            ack           <= 1'b0;
            resp_error    <= 1'b0;
        end
        else
        begin
            cmd.cmd_start <= 1'b0;
            done          <= 1'b0;
            ack           <= cmd.b_seen;  // One ack per B response.

            if (accept)
                resp_error <= 1'b0;  // New transfer clears the old status.
            else if (cmd.b_err)
                resp_error <= 1'b1;

            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        cmd.cmd_start <= 1'b1;
                        state         <= ST_WRITE;
                    end
                end

                ST_WRITE:
                begin
                    if (cmd.cmd_done)
                    begin
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                end

                ST_DONE:
                    state <= ST_IDLE;

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Command is held for the master until the transfer ends.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd.cmd_addr   <= start_addr;
            cmd.cmd_length <= length;
        end
    end

    // Bursts never cross a 4 KB page only if the start is burst-aligned.
    a_start_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> start_addr[$clog2(BURST_BYTES)-1:0] == '0);

endmodule

// ==== dma_write_top.sv ====
`timescale 1ns/1ps

module dma_write_top
(
    input  logic            clk,
    input  logic            rst_n,
    // Producer side.
    input  logic            wr_en,
    input  dma_pkg::data_t  wr_data,
    output logic            almost_full,
    // Control and status.
    input  logic            start,
    input  dma_pkg::addr_t  start_addr,
    input  dma_pkg::len_t   length,
    output logic            status_idle,
    output logic            status_active,
    output logic            done,
    output logic            ack,
    output logic            resp_error,
    // AXI4 write channels.
    output logic            awvalid,
    input  logic            awready,
    output dma_pkg::addr_t  awaddr,
    output dma_pkg::awlen_t awlen,
    output logic            wvalid,
    input  logic            wready,
    output dma_pkg::data_t  wdata,
    output dma_pkg::strb_t  wstrb,
    output logic            wlast,
    input  logic            bvalid,
    output logic            bready,
    input  logic [1:0]      bresp
);
    import dma_pkg::*;

    // FIFO head to the burst master.
    logic  tvalid;
    logic  tready;
    data_t tdata;

    burst_cmd_if u_cmd ();

    dma_send_fifo u_fifo
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .tvalid      (tvalid),
        .tready      (tready),
        .tdata       (tdata),
        .almost_full (almost_full)
    );

    dma_write_ctrl u_ctrl
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .start_addr    (start_addr),
        .length        (length),
        .cmd           (u_cmd.ctrl),
        .status_idle   (status_idle),
        .status_active (status_active),
        .done          (done),
        .ack           (ack),
        .resp_error    (resp_error)
    );

    dma_axi_write_master u_master
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (u_cmd.master),
        .tvalid  (tvalid),
        .tready  (tready),
        .tdata   (tdata),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp)
    );

endmodule

// ==== tb_dma_write.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module tb_dma_write;
    import dma_pkg::*;

    localparam logic [31:0] SEED       = 32'hb9c7_d79c;
    localparam int          LINE_BYTES = `DMA_DATA_W / 8;
    localparam int          NUM_TESTS  = 6;
    localparam int          FIFO_DEPTH = 1 << `DMA_FIFO_LOG2;

    // DUT inputs.
    logic       clk        = 1'b0;
    logic       rst_n      = 1'b0;
    logic       wr_en      = 1'b0;
    data_t      wr_data    = '0;
    logic       start      = 1'b0;
    addr_t      start_addr = '0;
    len_t       length     = '0;
    logic       awready    = 1'b0;
    logic       wready     = 1'b0;
    logic       bvalid     = 1'b0;
    logic [1:0] bresp      = 2'b00;

    // DUT outputs.
    logic   almost_full, status_idle, status_active, done, ack, resp_error;
    logic   awvalid, wvalid, wlast, bready;
    addr_t  awaddr;
    awlen_t awlen;
    data_t  wdata;
    strb_t  wstrb;

    // Slave memory model state.
    data_t       mem_model [addr_t];
    int          b_due [$];         // Cycle at which each B may be sent.
    int          b_num [$];         // Burst index of each pending B.
    int          cyc = 0;
    logic [31:0] slv_rng = SEED ^ 32'h5bd1_e995;
    logic [31:0] drv_rng = SEED;
    addr_t       t_start;
    len_t        t_len;
    logic        t_stall = 1'b0;
    int          t_err;
    logic        stall_cfg = 1'b0;
    int          err_cfg = -1;      // Burst that gets SLVERR, -1 for none.
    addr_t       cur_base;
    int          cur_beats;
    int          beat;
    logic        w_open = 1'b0;
    int          w_burst;
    int          fifo_level = 0;    // Lines held in the send FIFO.
    len_t        aw_cnt, beat_cnt, b_sent, ack_cnt, done_cnt;
    len_t        test_len [NUM_TESTS];
    int          wd_cycles = 0;

    dma_write_top u_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected line at a byte address, mixed with a per-test tag.
    function automatic data_t fill_line(input addr_t a, input logic [31:0] tag);
        return data_t'({a ^ tag, ~a + {tag[15:0], tag[31:16]}});
    endfunction

    function automatic len_t ref_burst_count(input len_t len);
        return (len + `DMA_BURST_LEN - 1) / `DMA_BURST_LEN;
    endfunction

    function automatic addr_t ref_burst_addr(input addr_t base, input len_t k);
        return base + addr_t'(k) * addr_t'(`DMA_BURST_LEN * LINE_BYTES);
    endfunction

    // Only the final burst may be short.
    function automatic len_t ref_burst_beats(input len_t len, input len_t k);
        len_t nb;
        nb = ref_burst_count(len);
        return (k < nb - 1) ? len_t'(`DMA_BURST_LEN) : len - `DMA_BURST_LEN * (nb - 1);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_line(input data_t got, input data_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Error %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Error %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_count(input len_t got, input len_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Error %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Error %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // AXI slave. Stores W beats, checks AW against the reference, answers B late.
    always @(posedge clk)
    begin
        cyc++;
        slv_rng = lcg(slv_rng);
        if (rst_n)
        begin
            check_flag(almost_full, (FIFO_DEPTH - fifo_level) <= `DMA_FIFO_AF_MARGIN,
                       "almost_full");
            fifo_level += int'(wr_en) - int'(wvalid && wready);
        end
        if (start)
        begin
            t_start  = start_addr;
            t_len    = length;
            t_stall  = stall_cfg;
            t_err    = err_cfg;
            aw_cnt   = 0;
            beat_cnt = 0;
            b_sent   = 0;
            w_burst  = 0;
            w_open   = 1'b0;
            mem_model.delete();
            b_due.delete();
            b_num.delete();
        end
        if (wvalid && wready)
        begin
            if (!w_open)
                stop_with_failure("A W beat arrived with no accepted AW request.");
            check_flag(wlast, beat == cur_beats - 1, "wlast");
            check_flag(&wstrb, 1'b1, "wstrb all ones");
            mem_model[cur_base + addr_t'(beat * LINE_BYTES)] = wdata;
            beat++;
            beat_cnt++;
            if (wlast)
            begin
                w_open = 1'b0;
                b_due.push_back(cyc + 1 + int'(slv_rng[20:18]));  // Random B delay.
                b_num.push_back(w_burst);
                w_burst++;
            end
        end
        if (awvalid && awready)
        begin
            if (w_open)
                stop_with_failure("An AW request came before the previous burst's wlast.");
            if (aw_cnt >= ref_burst_count(t_len))
                stop_with_failure("An AW request came beyond the expected burst count.");
            check_addr(awaddr, ref_burst_addr(t_start, aw_cnt), "awaddr");
            check_count(len_t'(awlen) + 1, ref_burst_beats(t_len, aw_cnt), "burst beats");
            cur_base  = awaddr;
            cur_beats = int'(awlen) + 1;
            beat      = 0;
            w_open    = 1'b1;
            aw_cnt++;
        end
        if (bvalid)
            check_flag(bready, 1'b1, "bready with a B response pending");
        if (bvalid && bready)
        begin
            bvalid <= 1'b0;
            b_sent++;
        end
        else if (!bvalid && b_due.size() != 0 && cyc >= b_due[0])
        begin
            bvalid <= 1'b1;
            bresp  <= (b_num[0] == t_err) ? 2'b10 : 2'b00;  // SLVERR on the chosen burst.
            void'(b_due.pop_front());
            void'(b_num.pop_front());
        end
        awready <= !t_stall || slv_rng[5] || slv_rng[9];
        wready  <= !t_stall || slv_rng[13] || slv_rng[17];
    end

    // Counts ack and done pulses per transfer.
    always @(posedge clk)
    begin
        if (start)
        begin
            ack_cnt  = 0;
            done_cnt = 0;
        end
        if (ack)
            ack_cnt++;
        if (done)
            done_cnt++;
    end

    // Producer, honoring almost_full.
    task automatic push_lines(input addr_t base, input len_t len, input logic [31:0] tag,
                              input logic gaps);
        len_t i;
        i = 0;
        while (i < len)
        begin
            @(posedge clk);
            drv_rng = lcg(drv_rng);
            if (!almost_full && (!gaps || drv_rng[7] || drv_rng[11]))
            begin
                wr_en   <= 1'b1;
                wr_data <= fill_line(base + addr_t'(i) * LINE_BYTES, tag);
                i++;
            end
            else
                wr_en <= 1'b0;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_transfer(input int test_no, input len_t len, input logic stalls,
                                input int bad_burst);
        addr_t       base;
        addr_t       a;
        logic [31:0] tag;
        len_t        nb;
        len_t        i;
        drv_rng = lcg(drv_rng);
        base    = (addr_t'(test_no) << 16) | (drv_rng & 32'h0000_ff80);  // Burst-aligned.
        drv_rng = lcg(drv_rng);
        tag     = drv_rng;
        nb      = ref_burst_count(len);
        @(posedge clk);
        start      <= 1'b1;
        start_addr <= base;
        length     <= len;
        stall_cfg  <= stalls;
        err_cfg    <= bad_burst;
        fork
            push_lines(base, len, tag, stalls);
            begin
                @(posedge clk);
                start <= 1'b0;
                @(posedge clk);
                check_flag(resp_error, 1'b0, "resp_error after start");
                while (!done)
                begin
                    check_flag(status_active, 1'b1, "status_active");
                    @(posedge clk);
                end
                check_count(b_sent, nb, "B responses before done");
            end
        join
        repeat (3) @(posedge clk);
        check_count(done_cnt, 1, "done pulses");
        check_count(ack_cnt, nb, "ack pulses");
        check_count(aw_cnt, nb, "AW requests");
        check_count(beat_cnt, len, "W beats");
        check_count(len_t'(mem_model.num()), len, "lines written");
        check_flag(status_idle, 1'b1, "status_idle after done");
        check_flag(resp_error, bad_burst >= 0, "resp_error after done");
        for (i = 0; i < len; i++)
        begin
            a = base + addr_t'(i) * LINE_BYTES;
            if (!mem_model.exists(a))
                stop_with_failure($sformatf("The line at address %h was never written.", a));
            check_line(mem_model[a], fill_line(a, tag), $sformatf("line at %h", a));
        end
    endtask

    // Watchdog.
    initial
    begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        stop_with_failure("Timeout: the transfers did not finish in time.");
    end

    initial
    begin
        int total;
        test_len[0] = 1;
        test_len[1] = 16;
        test_len[2] = 17;
        test_len[3] = 50;
        drv_rng     = lcg(drv_rng);
        test_len[4] = len_t'(17 + drv_rng[31:16] % 48);  // At least two bursts.
        drv_rng     = lcg(drv_rng);
        test_len[5] = len_t'(1 + drv_rng[31:16] % 64);
        total = 0;
        foreach (test_len[k])
            total += int'(test_len[k]);
        wd_cycles = total * 40 + 2000;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_flag(status_idle, 1'b1, "status_idle after reset");
        check_flag(awvalid, 1'b0, "awvalid after reset");
        check_flag(wvalid, 1'b0, "wvalid after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(ack, 1'b0, "ack after reset");
        check_flag(resp_error, 1'b0, "resp_error after reset");

        run_transfer(0, test_len[0], 1'b0, -1);
        run_transfer(1, test_len[1], 1'b0, -1);
        run_transfer(2, test_len[2], 1'b0, -1);
        run_transfer(3, test_len[3], 1'b1, -1);
        run_transfer(4, test_len[4], 1'b1, 1);
        repeat (5) @(posedge clk);
        check_flag(resp_error, 1'b1, "resp_error held while idle");
        run_transfer(5, test_len[5], 1'b1, -1);

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
dma_pkg.sv
dma_if.sv
dma_send_fifo.sv
dma_axi_write_master.sv
dma_write_ctrl.sv
dma_write_top.sv
tb_dma_write.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dma_write
FILELIST = compile.f
OUT_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OUT_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OUT_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OUT_DIR)
